/* common/ship_pkg.sv */
`default_nettype none

package ship_pkg;

  // visible area
  localparam int SCREEN_W = 800;
  localparam int SCREEN_H = 600;

  // ship box, fixed to one row band near the bottom
  localparam int SHIP_Y = 560;
  localparam int SHIP_W = 32;
  localparam int SHIP_H = 16;

  // player missile box
  localparam int MISSILE_W = 2;
  localparam int MISSILE_H = 8;

  // 4-bit r, g, b
  localparam logic [11:0] SHIP_RGB    = 12'h0f0;
  localparam logic [11:0] DEAD_RGB    = 12'hf00;
  localparam logic [11:0] MISSILE_RGB = 12'hff0;

  typedef logic [10:0] coord_t;

  // pixel stream between overlay stages
  typedef struct packed {
    coord_t      hcount;
    coord_t      vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    logic [11:0] rgb;
  } vga_timing_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } point_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   on;
  } missile_t;

  typedef enum logic {
    MISSILE_IDLE,
    MISSILE_FLYING
  } missile_state_e;

  typedef enum logic {
    SHIP_ALIVE,
    SHIP_DEAD
  } ship_state_e;

endpackage

`default_nettype wire

/* draw/missile_draw.sv */
`default_nettype none

module missile_draw (
  input  wire                        pclk,
  input  wire                        rst_n_i,
  input  wire ship_pkg::missile_t    missile_i,
  input  wire ship_pkg::vga_timing_t timing_i,
  output ship_pkg::vga_timing_t      timing_o
);

  import ship_pkg::*;

  logic        in_box;
  logic        paint;
  vga_timing_t timing_d;

  // missile box anchored at its top left corner
  assign in_box = (int'(timing_i.hcount) >= int'(missile_i.x)) &&
                  (int'(timing_i.hcount) <= int'(missile_i.x) + MISSILE_W - 1) &&
                  (int'(timing_i.vcount) >= int'(missile_i.y)) &&
                  (int'(timing_i.vcount) <= int'(missile_i.y) + MISSILE_H - 1);

  // nothing drawn while idle or blanking
  assign paint = missile_i.on && in_box && !timing_i.hblnk && !timing_i.vblnk;

  always_comb begin
    timing_d = timing_i;
    if (paint) begin
      timing_d.rgb = MISSILE_RGB;
    end
  end

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      timing_o <= '0;
    end else begin
      timing_o <= timing_d;
    end
  end

endmodule

`default_nettype wire

/* draw/ship_draw.sv */
`default_nettype none

module ship_draw (
  input  wire                        pclk,
  input  wire                        rst_n_i,
  input  wire                        ship_dead_i,
  input  wire ship_pkg::coord_t      ship_x_i,
  input  wire ship_pkg::vga_timing_t timing_i,
  output ship_pkg::vga_timing_t      timing_o
);

  import ship_pkg::*;

  localparam int BOX_TOP    = SHIP_Y;
  localparam int BOX_BOTTOM = SHIP_Y + SHIP_H - 1;

  logic        in_x;
  logic        in_y;
  logic        blank;
  logic        paint;
  logic [11:0] ship_rgb;
  vga_timing_t timing_d;

  // horizontal extent follows the moving ship
  assign in_x = (int'(timing_i.hcount) >= int'(ship_x_i)) &&
                (int'(timing_i.hcount) <= int'(ship_x_i) + SHIP_W - 1);

  // vertical extent is fixed
  assign in_y = (int'(timing_i.vcount) >= BOX_TOP) &&
                (int'(timing_i.vcount) <= BOX_BOTTOM);

  assign blank = timing_i.hblnk || timing_i.vblnk;
  assign paint = in_x && in_y && !blank;

  // colour tells alive from destroyed
  assign ship_rgb = ship_dead_i ? DEAD_RGB : SHIP_RGB;

  always_comb begin
    timing_d = timing_i;
    if (paint) begin
      timing_d.rgb = ship_rgb;
    end
  end

  // one clock of delay for the whole stream
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      timing_o <= '0;
    end else begin
      timing_o <= timing_d;
    end
  end

endmodule

`default_nettype wire

/* logic/hit_detect.sv */
`default_nettype none

module hit_detect #(
  parameter int N_ENEMY_MISSILES = 5
) (
  input  wire                                           pclk,
  input  wire                                           rst_n_i,
  input  wire ship_pkg::coord_t                         ship_x_i,
  input  wire ship_pkg::point_t [N_ENEMY_MISSILES-1:0]  enemy_missiles_i,
  output logic                                          ship_dead_o
);

  import ship_pkg::*;

  // ship box bounds, inclusive
  localparam int BOX_TOP    = SHIP_Y;
  localparam int BOX_BOTTOM = SHIP_Y + SHIP_H - 1;

  logic [N_ENEMY_MISSILES-1:0] hit_vec;
  logic                        hit_any;
  int                          box_left;
  int                          box_right;
  ship_state_e                 state_q;

  assign box_left  = int'(ship_x_i);
  assign box_right = int'(ship_x_i) + SHIP_W - 1;

  // every enemy point checked in parallel
  always_comb begin
    for (int i = 0; i < N_ENEMY_MISSILES; i++) begin
      hit_vec[i] = (int'(enemy_missiles_i[i].x) >= box_left) &&
                   (int'(enemy_missiles_i[i].x) <= box_right) &&
                   (int'(enemy_missiles_i[i].y) >= BOX_TOP) &&
                   (int'(enemy_missiles_i[i].y) <= BOX_BOTTOM);
    end
  end

  assign hit_any = |hit_vec;

  // sticky until reset
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= SHIP_ALIVE;
    end else begin
      case (state_q)
        SHIP_ALIVE: begin
          if (hit_any) begin
            state_q <= SHIP_DEAD;
          end
        end
        SHIP_DEAD: begin
          state_q <= SHIP_DEAD;
        end
        default: begin
          state_q <= SHIP_ALIVE;
        end
      endcase
    end
  end

  assign ship_dead_o = (state_q == SHIP_DEAD);

endmodule

`default_nettype wire

/* logic/missile_ctl.sv */
`default_nettype none

module missile_ctl #(
  parameter int MISSILE_STEP = 8
) (
  input  wire                     pclk,
  input  wire                     rst_n_i,
  input  wire                     frame_tick_i,
  input  wire                     fire_i,
  input  wire                     ship_dead_i,
  input  wire ship_pkg::coord_t   ship_x_i,
  output ship_pkg::missile_t      missile_o
);

  import ship_pkg::*;

  // launch point sits just above the ship, centred on it
  localparam int LAUNCH_Y = SHIP_Y - MISSILE_H;

  missile_state_e state_q;
  coord_t         x_q;
  coord_t         y_q;

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= MISSILE_IDLE;
      x_q     <= '0;
      y_q     <= '0;
    end else if (ship_dead_i) begin
      // destroyed ship takes its missile with it
      state_q <= MISSILE_IDLE;
      x_q     <= '0;
      y_q     <= '0;
    end else if (frame_tick_i) begin
      case (state_q)
        MISSILE_IDLE: begin
          if (fire_i) begin
            state_q <= MISSILE_FLYING;
            x_q     <= coord_t'(int'(ship_x_i) + SHIP_W / 2);
            y_q     <= coord_t'(LAUNCH_Y);
          end
        end
        MISSILE_FLYING: begin
          // retire before y would wrap past the top edge
          if (int'(y_q) < MISSILE_STEP) begin
            state_q <= MISSILE_IDLE;
          end else begin
            y_q <= coord_t'(int'(y_q) - MISSILE_STEP);
          end
        end
        default: begin
          state_q <= MISSILE_IDLE;
        end
      endcase
    end
  end

  // on flag is simply the flying state
  assign missile_o.x  = x_q;
  assign missile_o.y  = y_q;
  assign missile_o.on = (state_q == MISSILE_FLYING);

endmodule

`default_nettype wire

/* logic/player_ship.sv */
`default_nettype none

module player_ship #(
  parameter int SHIP_STEP        = 4,
  parameter int MISSILE_STEP     = 8,
  parameter int N_ENEMY_MISSILES = 5
) (
  input  wire                                           pclk,
  input  wire                                           rst_n_i,
  input  wire                                           left_i,
  input  wire                                           right_i,
  input  wire                                           fire_i,
  input  wire ship_pkg::vga_timing_t                    timing_i,
  input  wire ship_pkg::point_t [N_ENEMY_MISSILES-1:0]  enemy_missiles_i,
  output ship_pkg::vga_timing_t                         timing_o,
  output ship_pkg::missile_t                            missile_o,
  output ship_pkg::coord_t                              ship_x_o,
  output logic                                          ship_down_o
);

  import ship_pkg::*;

  logic        vblnk_q;
  logic        frame_tick;
  coord_t      ship_x;
  logic        ship_dead;
  missile_t    missile;
  vga_timing_t ship_stage;

  // rising edge of vertical blanking marks a new frame
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vblnk_q <= 1'b0;
    end else begin
      vblnk_q <= timing_i.vblnk;
    end
  end

  assign frame_tick = timing_i.vblnk && !vblnk_q;

  ship_position_ctl #(
    .SHIP_STEP (SHIP_STEP)
  ) u_ship_position_ctl (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .frame_tick_i (frame_tick),
    .left_i       (left_i),
    .right_i      (right_i),
    .ship_dead_i  (ship_dead),
    .ship_x_o     (ship_x)
  );

  missile_ctl #(
    .MISSILE_STEP (MISSILE_STEP)
  ) u_missile_ctl (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .frame_tick_i (frame_tick),
    .fire_i       (fire_i),
    .ship_dead_i  (ship_dead),
    .ship_x_i     (ship_x),
    .missile_o    (missile)
  );

  hit_detect #(
    .N_ENEMY_MISSILES (N_ENEMY_MISSILES)
  ) u_hit_detect (
    .pclk             (pclk),
    .rst_n_i          (rst_n_i),
    .ship_x_i         (ship_x),
    .enemy_missiles_i (enemy_missiles_i),
    .ship_dead_o      (ship_dead)
  );

  // ship first, so the missile lands on top of it
  ship_draw u_ship_draw (
    .pclk        (pclk),
    .rst_n_i     (rst_n_i),
    .ship_dead_i (ship_dead),
    .ship_x_i    (ship_x),
    .timing_i    (timing_i),
    .timing_o    (ship_stage)
  );

  missile_draw u_missile_draw (
    .pclk      (pclk),
    .rst_n_i   (rst_n_i),
    .missile_i (missile),
    .timing_i  (ship_stage),
    .timing_o  (timing_o)
  );

  assign missile_o   = missile;
  assign ship_x_o    = ship_x;
  assign ship_down_o = ship_dead;

endmodule

`default_nettype wire

/* logic/ship_position_ctl.sv */
`default_nettype none

module ship_position_ctl #(
  parameter int SHIP_STEP = 4
) (
  input  wire              pclk,
  input  wire              rst_n_i,
  input  wire              frame_tick_i,
  input  wire              left_i,
  input  wire              right_i,
  input  wire              ship_dead_i,
  output ship_pkg::coord_t ship_x_o
);

  import ship_pkg::*;

  // rightmost legal x, and the centred start position
  localparam int     X_MAX   = SCREEN_W - SHIP_W;
  localparam coord_t X_RESET = coord_t'(X_MAX / 2);

  coord_t ship_x_q;
  coord_t ship_x_d;
  int     x_left;
  int     x_right;

  // signed intermediates so the left clamp can see negative values
  always_comb begin
    x_left   = int'(ship_x_q) - SHIP_STEP;
    x_right  = int'(ship_x_q) + SHIP_STEP;
    ship_x_d = ship_x_q;
    if (left_i && !right_i) begin
      ship_x_d = (x_left < 0) ? '0 : coord_t'(x_left);
    end else if (right_i && !left_i) begin
      ship_x_d = (x_right > X_MAX) ? coord_t'(X_MAX) : coord_t'(x_right);
    end
  end

  // one step per frame, frozen once destroyed
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ship_x_q <= X_RESET;
    end else if (frame_tick_i && !ship_dead_i) begin
      ship_x_q <= ship_x_d;
    end
  end

  assign ship_x_o = ship_x_q;

endmodule

`default_nettype wire

/* tests/player_ship_sva.sv */
`default_nettype none

module player_ship_sva (
  input wire                        pclk,
  input wire                        rst_n_i,
  input wire ship_pkg::vga_timing_t timing_i,
  input wire ship_pkg::vga_timing_t timing_o,
  input wire ship_pkg::missile_t    missile_o,
  input wire                        ship_down_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import ship_pkg::*;

  int assert_fails = 0;

  // two overlay stages give two clocks of delay
  assert property (@(posedge pclk) disable iff (!rst_n_i)
    ($past(rst_n_i) && $past(rst_n_i, 2)) |-> (timing_o.hsync == $past(timing_i.hsync, 2)))
    else begin
      assert_fails++;
      $error("hsync not delayed by two clocks");
    end

  // destroyed state is sticky
  assert property (@(posedge pclk) $fell(ship_down_o) |-> !rst_n_i)
    else begin
      assert_fails++;
      $error("ship_down_o fell without reset");
    end

  // missile clears one clock after the hit
  assert property (@(posedge pclk) disable iff (!rst_n_i)
    (ship_down_o && $past(ship_down_o)) |-> !missile_o.on)
    else begin
      assert_fails++;
      $error("missile on while ship is down");
    end

endmodule

bind player_ship player_ship_sva u_player_ship_sva (
  .pclk        (pclk),
  .rst_n_i     (rst_n_i),
  .timing_i    (timing_i),
  .timing_o    (timing_o),
  .missile_o   (missile_o),
  .ship_down_o (ship_down_o)
);

`default_nettype wire

/* tests/player_ship_tb.sv */
`default_nettype none

module player_ship_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import ship_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int SHIP_STEP    = 4;
  localparam int MISSILE_STEP = 8;
  localparam int LINE_CLKS    = 80;
  localparam int N_ROWS       = 16;
  localparam int FIRST_ROW    = 556;
  localparam int FRAME_CLKS   = LINE_CLKS * (N_ROWS + 1);
  // about 300 movement frames, 72 firing frames and a handful for pixels and hits
  localparam int WATCHDOG_FRAMES = 420;

  logic        pclk = 1'b0;
  logic        rst_n;
  logic        left_btn;
  logic        right_btn;
  logic        fire_btn;
  vga_timing_t timing_in = '0;
  point_t [4:0] enemies;
  vga_timing_t timing_out;
  missile_t    missile;
  coord_t      ship_x;
  logic        ship_down;

  int          hcnt;
  int          row;
  int          frame_no = 0;
  int          err_count;
  int          tests_run;
  int          tests_failed;
  int          exp_x;
  int          exp_mx;
  int          exp_my;
  bit          exp_on;
  bit          exp_dead;
  logic [31:0] lfsr_q;

  player_ship #(
    .SHIP_STEP        (SHIP_STEP),
    .MISSILE_STEP     (MISSILE_STEP),
    .N_ENEMY_MISSILES (5)
  ) u_player_ship (
    .pclk             (pclk),
    .rst_n_i          (rst_n),
    .left_i           (left_btn),
    .right_i          (right_btn),
    .fire_i           (fire_btn),
    .timing_i         (timing_in),
    .enemy_missiles_i (enemies),
    .timing_o         (timing_out),
    .missile_o        (missile),
    .ship_x_o         (ship_x),
    .ship_down_o      (ship_down)
  );

  always #(CLK_PERIOD / 2) pclk = ~pclk;

  // shrunken stream where row 0 is vertical blanking on a ship row
  always @(posedge pclk) begin
    if (!rst_n) begin
      hcnt      <= 0;
      row       <= 0;
      timing_in <= '0;
    end else begin
      timing_in.hcount <= coord_t'(hcnt);
      timing_in.vcount <= coord_t'((row == 0) ? SHIP_Y + 2 : FIRST_ROW + row - 1);
      timing_in.hblnk  <= (hcnt >= 64);
      timing_in.hsync  <= (hcnt >= 68 && hcnt < 76);
      timing_in.vblnk  <= (row == 0);
      timing_in.vsync  <= (row == 0 && hcnt < 40);
      timing_in.rgb    <= 12'(hcnt * 7 + row * 13 + 1);
      if (row == 0 && hcnt == 0) begin
        frame_no <= frame_no + 1;
      end
      hcnt <= (hcnt == LINE_CLKS - 1) ? 0 : hcnt + 1;
      if (hcnt == LINE_CLKS - 1) begin
        row <= (row == N_ROWS) ? 0 : row + 1;
      end
    end
  end

  initial begin
    #(WATCHDOG_FRAMES * FRAME_CLKS * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("Test failed");
    $finish;
  end

  function automatic int rand_bits(input int n);
    int val;
    val = 0;
    repeat (n) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      val = (val << 1) | int'(lfsr_q[0]);
    end
    return val;
  endfunction

  task automatic check(input string name, input int exp, input int act);
    if (exp != act) begin
      err_count++;
      $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count != errs_before) begin
      tests_failed++;
      $display("%s: failed", name);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic set_buttons(input logic l, input logic r, input logic f);
    @(posedge pclk);
    left_btn  <= l;
    right_btn <= r;
    fire_btn  <= f;
    #1;
  endtask

  // returns just after the clock that follows the frame tick
  task automatic next_frame();
    int target;
    target = frame_no + 1;
    while (frame_no != target) @(posedge pclk);
    #1;
  endtask

  task automatic advance_frame();
    int old_x;
    old_x = exp_x;
    if (!exp_dead) begin
      if (left_btn && !right_btn) begin
        exp_x = (exp_x < SHIP_STEP) ? 0 : exp_x - SHIP_STEP;
      end else if (right_btn && !left_btn) begin
        exp_x = (exp_x + SHIP_STEP > SCREEN_W - SHIP_W) ? SCREEN_W - SHIP_W : exp_x + SHIP_STEP;
      end
      if (!exp_on && fire_btn) begin
        exp_on = 1'b1;
        exp_mx = old_x + SHIP_W / 2;
        exp_my = SHIP_Y - MISSILE_H;
      end else if (exp_on && exp_my < MISSILE_STEP) begin
        exp_on = 1'b0;
      end else if (exp_on) begin
        exp_my = exp_my - MISSILE_STEP;
      end
    end
    next_frame();
    check("ship_x_o", exp_x, ship_x);
    check("missile_o.on", exp_on, missile.on);
    if (exp_on) begin
      check("missile_o.x", exp_mx, missile.x);
      check("missile_o.y", exp_my, missile.y);
    end
    check("ship_down_o", exp_dead, ship_down);
  endtask

  // compares every output pixel with the input two clocks earlier
  task automatic scan_frame_pixels(output int ship_px, output int missile_px);
    vga_timing_t hist[3];
    vga_timing_t expv;
    int          hx;
    int          vy;
    ship_px    = 0;
    missile_px = 0;
    for (int i = 0; i < FRAME_CLKS - 4; i++) begin
      @(posedge pclk);
      #1;
      hist[2] = hist[1];
      hist[1] = hist[0];
      hist[0] = timing_in;
      if (i >= 2) begin
        expv = hist[2];
        hx   = int'(expv.hcount);
        vy   = int'(expv.vcount);
        if (!expv.hblnk && !expv.vblnk) begin
          if (exp_on && hx >= exp_mx && hx < exp_mx + MISSILE_W &&
              vy >= exp_my && vy < exp_my + MISSILE_H) begin
            expv.rgb = MISSILE_RGB;
            missile_px++;
          end else if (hx >= exp_x && hx < exp_x + SHIP_W && vy >= SHIP_Y &&
                       vy < SHIP_Y + SHIP_H) begin
            expv.rgb = exp_dead ? DEAD_RGB : SHIP_RGB;
            ship_px++;
          end
        end
        if (timing_out !== expv) begin
          err_count++;
          $display("Error at %0t ns: timing_o expected %h, got %h", $time, expv, timing_out);
        end
      end
    end
  endtask

  task automatic reset_test();
    int errs;
    errs = err_count;
    next_frame();
    check("ship_x_o", 384, ship_x);
    check("missile_o.on", 0, missile.on);
    check("ship_down_o", 0, ship_down);
    finish_test("reset", errs);
  endtask

  task automatic movement_test();
    int errs;
    errs = err_count;
    set_buttons(1'b0, 1'b1, 1'b0);
    repeat (100) advance_frame();
    set_buttons(1'b1, 1'b1, 1'b0);
    repeat (3) advance_frame();
    set_buttons(1'b1, 1'b0, 1'b0);
    repeat (200) advance_frame();
    set_buttons(1'b0, 1'b0, 1'b0);
    check("ship_x_o", 0, ship_x);
    finish_test("movement", errs);
  endtask

  task automatic fire_test();
    int errs;
    int frames;
    errs = err_count;
    frames = 0;
    // held button, so presses while flying are ignored
    set_buttons(1'b0, 1'b0, 1'b1);
    advance_frame();
    while (exp_on && frames < 100) begin
      advance_frame();
      frames++;
    end
    advance_frame();
    check("missile_o.on after relaunch", 1, missile.on);
    set_buttons(1'b0, 1'b0, 1'b0);
    finish_test("fire", errs);
  endtask

  task automatic pixel_test();
    int errs;
    int ship_px;
    int missile_px;
    errs = err_count;
    scan_frame_pixels(ship_px, missile_px);
    if (ship_px == 0 || missile_px == 0) begin
      err_count++;
      $display("the scanned frame did not cover both the ship and the missile");
    end
    finish_test("pixel overlay", errs);
  endtask

  task automatic hit_test();
    int errs;
    int v;
    int ship_px;
    int missile_px;
    errs = err_count;
    // points right of the ship box can never hit it
    @(posedge pclk);
    for (int k = 0; k < 5; k++) begin
      v = rand_bits(10);
      enemies[k].x <= coord_t'(64 + v % 700);
      v = rand_bits(10);
      enemies[k].y <= coord_t'(v % SCREEN_H);
    end
    repeat (3) advance_frame();
    @(posedge pclk);
    enemies[2] <= '{x: coord_t'(exp_x + 5), y: coord_t'(SHIP_Y + 3)};
    @(posedge pclk);
    #1;
    exp_dead = 1'b1;
    check("ship_down_o", 1, ship_down);
    @(posedge pclk);
    #1;
    exp_on = 1'b0;
    check("missile_o.on", 0, missile.on);
    @(posedge pclk);
    enemies <= '0;
    set_buttons(1'b0, 1'b1, 1'b1);
    repeat (3) advance_frame();
    set_buttons(1'b0, 1'b0, 1'b0);
    scan_frame_pixels(ship_px, missile_px);
    if (ship_px == 0) begin
      err_count++;
      $display("the scanned frame held no pixel of the destroyed ship");
    end
    finish_test("hit", errs);
  endtask

  initial begin
    rst_n     = 1'b0;
    left_btn  = 1'b0;
    right_btn = 1'b0;
    fire_btn  = 1'b0;
    enemies   = '0;
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    lfsr_q    = 32'hd577c99d;
    exp_x     = 384;
    exp_mx    = 0;
    exp_my    = 0;
    exp_on    = 1'b0;
    exp_dead  = 1'b0;
    repeat (16) @(posedge pclk);
    if (timing_out !== '0) begin
      err_count++;
      $display("timing_o was not cleared by reset");
    end
    rst_n <= 1'b1;
    reset_test();
    movement_test();
    fire_test();
    pixel_test();
    hit_test();
    if (u_player_ship.u_player_ship_sva.assert_fails != 0) begin
      err_count += u_player_ship.u_player_ship_sva.assert_fails;
      $display("the bound assertions failed %0d times",
               u_player_ship.u_player_ship_sva.assert_fails);
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/ship_pkg.sv
logic/ship_position_ctl.sv
logic/missile_ctl.sv
logic/hit_detect.sv
draw/ship_draw.sv
draw/missile_draw.sv
logic/player_ship.sv
tests/player_ship_sva.sv
tests/player_ship_tb.sv
